// File: Bender.yml
package:
  name: branch_rs

sources:
  - logic/brs_pkg.sv
  - logic/rs_entry_buffer.sv
  - logic/branch_resolver.sv
  - logic/branch_rs_top.sv
  - target: test
    files:
      - bench/branch_rs_properties.sv
      - bench/branch_rs_tb.sv

// File: bench/branch_rs_properties.sv
`timescale 1ns/10ps

module branch_rs_properties (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    flush_i,
    input  logic    ready_i,        // Station ready_o
    input  logic    cdb_strobe_i,   // Station cdb_valid_o
    input  logic    ex_valid_i,     // Issue strobe into the resolver
    input  logic    res_valid_i     // Resolver result strobe
);

    int assert_errors = 0;          // Failure tally

    // Flush silences the CDB at once
    a_flush_quiets_cdb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !cdb_strobe_i)
        else begin
            assert_errors++;
            $error("CDB strobe in the cycle after a flush");
        end

    a_flush_frees_tail: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> ready_i)        // Tail slot empty again
        else begin
            assert_errors++;
            $error("ready_o low in the cycle after a flush");
        end

    // Fixed one cycle resolver latency
    a_res_after_ex: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i |-> $past(ex_valid_i))
        else begin
            assert_errors++;
            $error("Resolver result without an issue one cycle earlier");
        end

    a_cdb_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(cdb_strobe_i))
        else begin
            assert_errors++;
            $error("cdb_valid_o is unknown after reset");
        end

endmodule

bind branch_rs_top branch_rs_properties i_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .ready_i      (ready_o),
    .cdb_strobe_i (cdb_valid_o),
    .ex_valid_i   (ex_valid),
    .res_valid_i  (res_valid)
);

// File: bench/branch_rs_tb.sv
`timescale 1ns/10ps

module branch_rs_tb;

    localparam int unsigned RS_DEPTH        = 4;
    localparam int          WATCHDOG_CYCLES = 400;  // All six tests with ample margin
    localparam int          WAIT_LIMIT      = 50;   // Longest single wait in cycles

    logic                   clk_i, rst_n_i, flush_i, valid_i, ready_o;
    brs_pkg::branch_type_t  branch_type_i;
    logic                   rs1_ready_i, rs2_ready_i, pred_taken_i;
    brs_pkg::rob_idx_t      rs1_tag_i, rs2_tag_i, dest_tag_i;
    brs_pkg::xlen_t         rs1_value_i, rs2_value_i, pc_i, pred_target_i;
    brs_pkg::b_imm_t        imm_i;
    logic                   cdb_valid_i, cdb_valid_o;
    brs_pkg::rob_idx_t      cdb_tag_i, cdb_tag_o;
    brs_pkg::xlen_t         cdb_value_i, cdb_value_o;

    // Expected CDB results in push order
    brs_pkg::rob_idx_t      exp_tag_q[$];
    brs_pkg::xlen_t         exp_value_q[$];

    int     value_errors    = 0;
    int     protocol_errors = 0;
    int     strobes         = 0;    // CDB strobes seen so far
    int     total_errors;
    string  test_name       = "reset";

    branch_rs_top #(.RS_DEPTH(RS_DEPTH)) i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;     // 100 ns period
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // Reference model of the resolver
    function automatic logic branch_taken(brs_pkg::branch_type_t t, brs_pkg::xlen_t a,
                                          brs_pkg::xlen_t b);
        case (t)
            brs_pkg::BEQ:  return a == b;
            brs_pkg::BNE:  return a != b;
            brs_pkg::BLT:  return $signed(a) < $signed(b);
            brs_pkg::BGE:  return !($signed(a) < $signed(b));
            brs_pkg::BLTU: return a < b;
            default:       return !(a < b);    // BGEU
        endcase
    endfunction

    function automatic brs_pkg::xlen_t branch_target(brs_pkg::xlen_t pc, brs_pkg::b_imm_t imm);
        int offset;
        offset = $signed(imm);          // Sign extension to 32 bits
        return pc + offset;
    endfunction

    function automatic logic expected_mispredict(brs_pkg::branch_type_t t, brs_pkg::xlen_t a,
                                                 brs_pkg::xlen_t b, brs_pkg::b_imm_t imm,
                                                 brs_pkg::xlen_t pc, brs_pkg::xlen_t ptarget,
                                                 logic ptaken);
        logic taken;
        taken = branch_taken(t, a, b);
        return (taken != ptaken) || (taken && (branch_target(pc, imm) != ptarget));
    endfunction

    task automatic check_tag(brs_pkg::rob_idx_t exp, brs_pkg::rob_idx_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: CDB tag expected %0d actual %0d", test_name, exp, act);
        end
    endtask

    task automatic check_value(brs_pkg::xlen_t exp, brs_pkg::xlen_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: CDB value expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_ready(logic exp, logic act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: ready_o expected %b actual %b", test_name, exp, act);
        end
    endtask

    task automatic check_count(int exp, int act);
        if (act != exp) begin
            value_errors++;
            $display("FAIL %s: count expected %0d actual %0d", test_name, exp, act);
        end
    endtask

    // CDB monitor samples mid-cycle where outputs are settled
    always @(negedge clk_i) begin
        if (rst_n_i && cdb_valid_o === 1'b1) begin
            strobes++;
            if (exp_tag_q.size() == 0) begin
                protocol_errors++;
                $display("%s: CDB strobe with tag %0d arrived when no result was expected",
                         test_name, cdb_tag_o);
            end else begin
                check_tag(exp_tag_q.pop_front(), cdb_tag_o);
                check_value(exp_value_q.pop_front(), cdb_value_o);
            end
        end
    end

    // Push one branch with a and b as the final operand values
    task automatic push_branch(brs_pkg::branch_type_t t, brs_pkg::xlen_t a, logic a_rdy,
                               brs_pkg::rob_idx_t a_tag, brs_pkg::xlen_t b, logic b_rdy,
                               brs_pkg::rob_idx_t b_tag, brs_pkg::b_imm_t imm,
                               brs_pkg::xlen_t pc, brs_pkg::xlen_t ptarget, logic ptaken,
                               brs_pkg::rob_idx_t dest);
        int waited;
        waited        = 0;
        valid_i       = 1'b1;
        branch_type_i = t;
        rs1_ready_i   = a_rdy;
        rs1_tag_i     = a_tag;
        rs1_value_i   = a_rdy ? a : ~a;     // Stale value while waiting
        rs2_ready_i   = b_rdy;
        rs2_tag_i     = b_tag;
        rs2_value_i   = b_rdy ? b : ~b;
        imm_i         = imm;
        pc_i          = pc;
        pred_target_i = ptarget;
        pred_taken_i  = ptaken;
        dest_tag_i    = dest;
        while (ready_o !== 1'b1 && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            #10;
            waited++;
        end
        if (waited == WAIT_LIMIT) begin
            protocol_errors++;
            $display("%s: ready_o stayed low, branch %0d was never accepted", test_name, dest);
            valid_i = 1'b0;
        end else begin
            @(posedge clk_i);               // Push edge
            exp_tag_q.push_back(dest);
            exp_value_q.push_back(
                brs_pkg::xlen_t'(expected_mispredict(t, a, b, imm, pc, ptarget, ptaken)));
            #10 valid_i = 1'b0;
        end
    endtask

    task automatic cdb_send(brs_pkg::rob_idx_t tag, brs_pkg::xlen_t value);
        cdb_valid_i = 1'b1;
        cdb_tag_i   = tag;
        cdb_value_i = value;
        @(posedge clk_i);
        #10 cdb_valid_i = 1'b0;
    endtask

    // Wait until every expected result has left
    task automatic drain();
        int n;
        n = 0;
        while (exp_tag_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        if (exp_tag_q.size() != 0) begin
            protocol_errors++;
            $display("%s: %0d results never appeared on the CDB", test_name, exp_tag_q.size());
            exp_tag_q.delete();
            exp_value_q.delete();
        end
        repeat (2) @(posedge clk_i);
        #10;
    endtask

    task automatic test_types();
        brs_pkg::branch_type_t  t;
        brs_pkg::xlen_t         a, b, pc, tgt, tmp;
        brs_pkg::b_imm_t        imm;
        brs_pkg::rob_idx_t      dest;
        logic                   taken;
        test_name = "test_types";
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 3; k++) begin
                t     = brs_pkg::branch_type_t'(i);
                a     = $urandom();
                b     = (k == 1) ? a : $urandom();     // Equal operands now and then
                if (k == 2 && t == brs_pkg::BEQ) begin
                    b = a;                              // Wrong target needs a taken branch
                end else if (k == 2 && !branch_taken(t, a, b)) begin
                    tmp = a;                            // Swapped operands take the branch
                    a   = b;
                    b   = tmp;
                end
                pc    = $urandom() & 32'hffff_fffc;
                imm   = $urandom();
                tgt   = branch_target(pc, imm);
                taken = branch_taken(t, a, b);
                dest  = brs_pkg::rob_idx_t'(3 * i + k);
                case (k)
                    0:       push_branch(t, a, 1, 0, b, 1, 0, imm, pc, tgt, taken, dest);
                    1:       push_branch(t, a, 1, 0, b, 1, 0, imm, pc, tgt, !taken, dest);
                    default: push_branch(t, a, 1, 0, b, 1, 0, imm, pc, tgt + 4, 1'b1, dest);
                endcase
            end
        end
        drain();
    endtask

    task automatic test_latency();
        int first;
        test_name = "test_latency";
        first     = 0;
        push_branch(brs_pkg::BEQ, 5, 1, 0, 5, 1, 0, 13'd8, 32'h100, 32'h108, 1'b1, 4'd3);
        for (int n = 1; n <= 6 && first == 0; n++) begin
            @(negedge clk_i);
            if (cdb_valid_o === 1'b1) first = n;    // Cycles counted from the push edge
        end
        check_count(3, first);
        drain();
    endtask

    task automatic test_cdb_wakeup();
        brs_pkg::xlen_t a, b, c;
        int             base;
        test_name = "test_cdb_wakeup";
        a         = $urandom();
        b         = $urandom();
        c         = $urandom();
        base      = strobes;
        // rs1 waits on tag 5 and the branch jumps back 16 bytes
        push_branch(brs_pkg::BLT, a, 0, 5, b, 1, 0, 13'h1ff0, 32'h2000, 32'h1ff0, 1'b1, 4'd1);
        push_branch(brs_pkg::BGEU, b, 0, 6, c, 0, 7, 13'd64, 32'h3000, 32'h3040, 1'b0, 4'd2);
        repeat (3) @(posedge clk_i);
        #10;
        check_count(0, strobes - base);     // Nothing leaves before its operands
        cdb_send(5, a);
        cdb_send(6, b);
        cdb_send(7, c);
        drain();
    endtask

    task automatic test_order();
        brs_pkg::xlen_t a, b;
        int             base;
        test_name = "test_order";
        a         = $urandom();
        b         = $urandom();
        base      = strobes;
        push_branch(brs_pkg::BNE, a, 1, 0, b, 0, 9, 13'd32, 32'h400, 32'h420, 1'b1, 4'd10);
        push_branch(brs_pkg::BEQ, a, 1, 0, a, 1, 0, 13'd12, 32'h500, 32'h50c, 1'b1, 4'd11);
        repeat (4) @(posedge clk_i);
        #10;
        check_count(0, strobes - base);     // Younger one must not overtake
        cdb_send(9, b);
        drain();
    endtask

    task automatic test_full();
        brs_pkg::xlen_t vals [RS_DEPTH];
        int             base;
        test_name = "test_full";
        for (int i = 0; i < RS_DEPTH; i++) begin
            vals[i] = $urandom();
            push_branch(brs_pkg::BLTU, vals[i], 0, brs_pkg::rob_idx_t'(i), 32'h8000_0000, 1, 0,
                        13'd16, 32'h600, 32'h610, 1'b1, brs_pkg::rob_idx_t'(i + 4));
        end
        check_ready(1'b0, ready_o);
        // Ready branch offered to a full station
        valid_i       = 1'b1;
        rs1_ready_i   = 1'b1;
        rs2_ready_i   = 1'b1;
        dest_tag_i    = 4'd15;
        repeat (3) @(posedge clk_i);
        #10 valid_i = 1'b0;
        base = strobes;
        for (int i = 0; i < RS_DEPTH; i++) cdb_send(brs_pkg::rob_idx_t'(i), vals[i]);
        drain();
        check_count(RS_DEPTH, strobes - base);
        check_ready(1'b1, ready_o);
    endtask

    task automatic test_flush();
        brs_pkg::xlen_t a, b;
        int             base;
        test_name = "test_flush";
        a         = $urandom();
        b         = $urandom();
        base      = strobes;
        // Oldest waits on tag 3 and the rest on tag 2
        for (int i = 0; i < RS_DEPTH; i++) begin
            push_branch(brs_pkg::BGE, a, 0, brs_pkg::rob_idx_t'((i == 0) ? 3 : 2), b, 1, 0,
                        13'd8, 32'h700, 32'h708, 1'b1, brs_pkg::rob_idx_t'(i + 4));
        end
        check_ready(1'b0, ready_o);
        cdb_send(3, a);                     // Oldest issues in the next cycle
        flush_i = 1'b1;                     // Flush lands while it enters the resolver
        @(posedge clk_i);
        #10 flush_i = 1'b0;
        exp_tag_q.delete();
        exp_value_q.delete();
        cdb_send(2, a);                     // Would wake the flushed entries
        repeat (4) @(posedge clk_i);
        #10;
        check_count(0, strobes - base);
        check_ready(1'b1, ready_o);
        push_branch(brs_pkg::BLT, a, 1, 0, b, 1, 0, 13'd20, 32'h900, 32'h914, 1'b0, 4'd6);
        drain();
        check_count(1, strobes - base);
    endtask

    initial begin
        void'($urandom(32'h7a608059));
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        valid_i       = 1'b0;
        branch_type_i = brs_pkg::BEQ;
        rs1_ready_i   = 1'b0;
        rs1_tag_i     = '0;
        rs1_value_i   = '0;
        rs2_ready_i   = 1'b0;
        rs2_tag_i     = '0;
        rs2_value_i   = '0;
        imm_i         = '0;
        pc_i          = '0;
        pred_target_i = '0;
        pred_taken_i  = 1'b0;
        dest_tag_i    = '0;
        cdb_valid_i   = 1'b0;
        cdb_tag_i     = '0;
        cdb_value_i   = '0;
        repeat (3) @(posedge clk_i);
        #10 rst_n_i = 1'b1;
        check_ready(1'b1, ready_o);
        test_types();
        test_latency();
        test_cdb_wakeup();
        test_order();
        test_full();
        test_flush();
        total_errors = value_errors + protocol_errors + i_dut.i_props.assert_errors;
        $display("Errors: %0d value, %0d protocol, %0d assertion", value_errors,
                 protocol_errors, i_dut.i_props.assert_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: logic/branch_resolver.sv
`timescale 1ns/10ps

module branch_resolver (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,

    input  logic                    ex_valid_i,
    input  brs_pkg::branch_type_t   ex_type_i,
    input  brs_pkg::xlen_t          ex_rs1_i,
    input  brs_pkg::xlen_t          ex_rs2_i,
    input  brs_pkg::b_imm_t         ex_imm_i,
    input  brs_pkg::xlen_t          ex_pc_i,
    input  brs_pkg::xlen_t          ex_pred_target_i,
    input  logic                    ex_pred_taken_i,

    output logic                    res_valid_o,
    output logic                    res_mispredict_o
);

    logic            taken;         // Actual direction
    brs_pkg::xlen_t  target;        // Actual target when taken
    brs_pkg::xlen_t  imm_sext;
    logic            mispredict;

    // Condition evaluation
    always_comb begin
        unique case (ex_type_i)
            brs_pkg::BEQ:  taken = (ex_rs1_i == ex_rs2_i);
            brs_pkg::BNE:  taken = (ex_rs1_i != ex_rs2_i);
            brs_pkg::BLT:  taken = ($signed(ex_rs1_i) <  $signed(ex_rs2_i));
            brs_pkg::BGE:  taken = ($signed(ex_rs1_i) >= $signed(ex_rs2_i));
            brs_pkg::BLTU: taken = (ex_rs1_i <  ex_rs2_i);
            brs_pkg::BGEU: taken = (ex_rs1_i >= ex_rs2_i);
            default:       taken = 1'b0;    // Unused encodings fall through
        endcase
    end

    // Offset is a signed byte count
    assign imm_sext = {{(brs_pkg::XLEN-brs_pkg::B_IMM_LEN){ex_imm_i[brs_pkg::B_IMM_LEN-1]}},
                       ex_imm_i};
    assign target   = ex_pc_i + imm_sext;

    // Wrong direction, or taken to the wrong place
    assign mispredict = (taken != ex_pred_taken_i)
                        || (taken && (target != ex_pred_target_i));

    // One cycle latency, a new branch can enter every cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= ex_valid_i && !flush_i;  // Flushed branch never reports
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i) res_mispredict_o <= mispredict;
    end

endmodule

// File: logic/branch_rs_top.sv
`timescale 1ns/10ps

module branch_rs_top #(
    parameter int unsigned RS_DEPTH = 4     // Station entries
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,

    // Issue side
    input  logic                    valid_i,
    output logic                    ready_o,
    input  brs_pkg::branch_type_t   branch_type_i,
    input  logic                    rs1_ready_i,
    input  brs_pkg::rob_idx_t       rs1_tag_i,
    input  brs_pkg::xlen_t          rs1_value_i,
    input  logic                    rs2_ready_i,
    input  brs_pkg::rob_idx_t       rs2_tag_i,
    input  brs_pkg::xlen_t          rs2_value_i,
    input  brs_pkg::b_imm_t         imm_i,
    input  brs_pkg::xlen_t          pc_i,
    input  brs_pkg::xlen_t          pred_target_i,
    input  logic                    pred_taken_i,
    input  brs_pkg::rob_idx_t       dest_tag_i,

    // CDB in
    input  logic                    cdb_valid_i,
    input  brs_pkg::rob_idx_t       cdb_tag_i,
    input  brs_pkg::xlen_t          cdb_value_i,

    // CDB out
    output logic                    cdb_valid_o,
    output brs_pkg::rob_idx_t       cdb_tag_o,
    output brs_pkg::xlen_t          cdb_value_o
);

    // Issue bundle, buffer to resolver
    logic                   ex_valid;
    brs_pkg::branch_type_t  ex_type;
    brs_pkg::xlen_t         ex_rs1;
    brs_pkg::xlen_t         ex_rs2;
    brs_pkg::b_imm_t        ex_imm;
    brs_pkg::xlen_t         ex_pc;
    brs_pkg::xlen_t         ex_pred_target;
    logic                   ex_pred_taken;

    // Result, resolver back to buffer
    logic                   res_valid;
    logic                   res_mispredict;

    rs_entry_buffer #(
        .RS_DEPTH         (RS_DEPTH)
    ) i_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .valid_i          (valid_i),
        .ready_o          (ready_o),
        .branch_type_i    (branch_type_i),
        .rs1_ready_i      (rs1_ready_i),
        .rs1_tag_i        (rs1_tag_i),
        .rs1_value_i      (rs1_value_i),
        .rs2_ready_i      (rs2_ready_i),
        .rs2_tag_i        (rs2_tag_i),
        .rs2_value_i      (rs2_value_i),
        .imm_i            (imm_i),
        .pc_i             (pc_i),
        .pred_target_i    (pred_target_i),
        .pred_taken_i     (pred_taken_i),
        .dest_tag_i       (dest_tag_i),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_tag_i        (cdb_tag_i),
        .cdb_value_i      (cdb_value_i),
        .ex_valid_o       (ex_valid),
        .ex_type_o        (ex_type),
        .ex_rs1_o         (ex_rs1),
        .ex_rs2_o         (ex_rs2),
        .ex_imm_o         (ex_imm),
        .ex_pc_o          (ex_pc),
        .ex_pred_target_o (ex_pred_target),
        .ex_pred_taken_o  (ex_pred_taken),
        .res_valid_i      (res_valid),
        .res_mispredict_i (res_mispredict),
        .cdb_valid_o      (cdb_valid_o),
        .cdb_tag_o        (cdb_tag_o),
        .cdb_value_o      (cdb_value_o)
    );

    branch_resolver i_resolver (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .ex_valid_i       (ex_valid),
        .ex_type_i        (ex_type),
        .ex_rs1_i         (ex_rs1),
        .ex_rs2_i         (ex_rs2),
        .ex_imm_i         (ex_imm),
        .ex_pc_i          (ex_pc),
        .ex_pred_target_i (ex_pred_target),
        .ex_pred_taken_i  (ex_pred_taken),
        .res_valid_o      (res_valid),
        .res_mispredict_o (res_mispredict)
    );

endmodule

// File: logic/brs_pkg.sv
// Widths and types shared by the branch reservation station and its bench
package brs_pkg;

    // Data path width
    localparam int unsigned XLEN        = 32;

    // Reorder-buffer tag width, also the CDB tag width
    localparam int unsigned ROB_IDX_LEN = 4;

    // Branch offset field, signed, in bytes
    localparam int unsigned B_IMM_LEN   = 13;

    // Operands, PCs and CDB values
    typedef logic [XLEN-1:0]        xlen_t;

    // ROB entry tag
    typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

    // Raw immediate as it leaves decode
    typedef logic [B_IMM_LEN-1:0]   b_imm_t;

    // Conditional branch flavours
    typedef enum logic [2:0] {
        BEQ  = 3'd0,    // Equal
        BNE  = 3'd1,    // Not equal
        BLT  = 3'd2,    // Less than, signed
        BGE  = 3'd3,    // Greater or equal, signed
        BLTU = 3'd4,    // Less than, unsigned
        BGEU = 3'd5     // Greater or equal, unsigned
    } branch_type_t;

endpackage

// File: logic/rs_entry_buffer.sv
`timescale 1ns/10ps

module rs_entry_buffer #(
    parameter int unsigned RS_DEPTH = 4     // Power of two, 2 or more
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,

    // Issue side
    input  logic                    valid_i,
    output logic                    ready_o,
    input  brs_pkg::branch_type_t   branch_type_i,
    input  logic                    rs1_ready_i,
    input  brs_pkg::rob_idx_t       rs1_tag_i,
    input  brs_pkg::xlen_t          rs1_value_i,
    input  logic                    rs2_ready_i,
    input  brs_pkg::rob_idx_t       rs2_tag_i,
    input  brs_pkg::xlen_t          rs2_value_i,
    input  brs_pkg::b_imm_t         imm_i,
    input  brs_pkg::xlen_t          pc_i,
    input  brs_pkg::xlen_t          pred_target_i,
    input  logic                    pred_taken_i,
    input  brs_pkg::rob_idx_t       dest_tag_i,

    // CDB snoop
    input  logic                    cdb_valid_i,
    input  brs_pkg::rob_idx_t       cdb_tag_i,
    input  brs_pkg::xlen_t          cdb_value_i,

    // To the resolver
    output logic                    ex_valid_o,
    output brs_pkg::branch_type_t   ex_type_o,
    output brs_pkg::xlen_t          ex_rs1_o,
    output brs_pkg::xlen_t          ex_rs2_o,
    output brs_pkg::b_imm_t         ex_imm_o,
    output brs_pkg::xlen_t          ex_pc_o,
    output brs_pkg::xlen_t          ex_pred_target_o,
    output logic                    ex_pred_taken_o,

    // Back from the resolver, in issue order
    input  logic                    res_valid_i,
    input  logic                    res_mispredict_i,

    // CDB broadcast
    output logic                    cdb_valid_o,
    output brs_pkg::rob_idx_t       cdb_tag_o,
    output brs_pkg::xlen_t          cdb_value_o
);

    localparam int unsigned PTR_W = $clog2(RS_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;    // Wraps naturally, depth is a power of two

    // Entry status flags
    logic   valid_q     [RS_DEPTH];     // Slot holds an instruction
    logic   busy_q      [RS_DEPTH];     // Already sent to the resolver
    logic   rs1_ready_q [RS_DEPTH];
    logic   rs2_ready_q [RS_DEPTH];
    logic   res_ready_q [RS_DEPTH];     // Mispredict bit stored, waiting for CDB

    // Entry payload
    brs_pkg::branch_type_t  type_q        [RS_DEPTH];
    brs_pkg::rob_idx_t      rs1_tag_q     [RS_DEPTH];
    brs_pkg::xlen_t         rs1_value_q   [RS_DEPTH];
    brs_pkg::rob_idx_t      rs2_tag_q     [RS_DEPTH];
    brs_pkg::xlen_t         rs2_value_q   [RS_DEPTH];
    brs_pkg::b_imm_t        imm_q         [RS_DEPTH];
    brs_pkg::xlen_t         pc_q          [RS_DEPTH];
    brs_pkg::xlen_t         pred_target_q [RS_DEPTH];
    logic                   pred_taken_q  [RS_DEPTH];
    brs_pkg::rob_idx_t      dest_tag_q    [RS_DEPTH];
    logic                   mispredict_q  [RS_DEPTH];

    // Ring pointers
    ptr_t   tail_q;     // Next free slot
    ptr_t   ex_q;       // Next to issue
    ptr_t   wr_res_q;   // Next to receive a result
    ptr_t   head_q;     // Oldest, next on the CDB

    logic   rs1_hit [RS_DEPTH];
    logic   rs2_hit [RS_DEPTH];
    logic   push, ex_fire, wr_fire, pop;

    // CDB tag match for every waiting operand
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rs1_hit[i] = cdb_valid_i && valid_q[i] && !rs1_ready_q[i]
                         && (rs1_tag_q[i] == cdb_tag_i);
            rs2_hit[i] = cdb_valid_i && valid_q[i] && !rs2_ready_q[i]
                         && (rs2_tag_q[i] == cdb_tag_i);
        end
    end

    assign ready_o = !valid_q[tail_q];      // Tail slot free
    assign push    = valid_i && ready_o;
    assign ex_fire = valid_q[ex_q] && rs1_ready_q[ex_q] && rs2_ready_q[ex_q] && !busy_q[ex_q];
    // Busy check drops a stale result after a flush
    assign wr_fire = res_valid_i && busy_q[wr_res_q] && !res_ready_q[wr_res_q];
    assign pop     = valid_q[head_q] && res_ready_q[head_q];

    // Flags and pointers
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tail_q   <= '0;
            ex_q     <= '0;
            wr_res_q <= '0;
            head_q   <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                valid_q[i]     <= 1'b0;
                busy_q[i]      <= 1'b0;
                rs1_ready_q[i] <= 1'b0;
                rs2_ready_q[i] <= 1'b0;
                res_ready_q[i] <= 1'b0;
            end
        end else if (flush_i) begin     // Drop everything, payload left as is
            tail_q   <= '0;
            ex_q     <= '0;
            wr_res_q <= '0;
            head_q   <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                valid_q[i]     <= 1'b0;
                busy_q[i]      <= 1'b0;
                rs1_ready_q[i] <= 1'b0;
                rs2_ready_q[i] <= 1'b0;
                res_ready_q[i] <= 1'b0;
            end
        end else begin
            // Wake-up from the CDB
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (rs1_hit[i]) rs1_ready_q[i] <= 1'b1;
                if (rs2_hit[i]) rs2_ready_q[i] <= 1'b1;
            end

            if (push) begin     // Tail slot is free, no wake-up can hit it
                valid_q[tail_q]     <= 1'b1;
                busy_q[tail_q]      <= 1'b0;
                rs1_ready_q[tail_q] <= rs1_ready_i;
                rs2_ready_q[tail_q] <= rs2_ready_i;
                res_ready_q[tail_q] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end

            if (ex_fire) begin
                busy_q[ex_q] <= 1'b1;           // Stays set until the slot is freed
                ex_q         <= ex_q + 1'b1;
            end

            if (wr_fire) begin
                res_ready_q[wr_res_q] <= 1'b1;
                wr_res_q              <= wr_res_q + 1'b1;
            end

            if (pop) begin      // Head is valid, tail is not, so never the pushed slot
                valid_q[head_q]     <= 1'b0;
                busy_q[head_q]      <= 1'b0;
                res_ready_q[head_q] <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
        end
    end

    // Payload, qualified by the flags above
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (rs1_hit[i]) rs1_value_q[i] <= cdb_value_i;
            if (rs2_hit[i]) rs2_value_q[i] <= cdb_value_i;
        end
        if (push) begin
            type_q[tail_q]        <= branch_type_i;
            rs1_tag_q[tail_q]     <= rs1_tag_i;
            rs1_value_q[tail_q]   <= rs1_value_i;
            rs2_tag_q[tail_q]     <= rs2_tag_i;
            rs2_value_q[tail_q]   <= rs2_value_i;
            imm_q[tail_q]         <= imm_i;
            pc_q[tail_q]          <= pc_i;
            pred_target_q[tail_q] <= pred_target_i;
            pred_taken_q[tail_q]  <= pred_taken_i;
            dest_tag_q[tail_q]    <= dest_tag_i;
        end
        if (wr_fire) mispredict_q[wr_res_q] <= res_mispredict_i;
    end

    // Issue port reads the execute slot
    assign ex_valid_o       = ex_fire;
    assign ex_type_o        = type_q[ex_q];
    assign ex_rs1_o         = rs1_value_q[ex_q];
    assign ex_rs2_o         = rs2_value_q[ex_q];
    assign ex_imm_o         = imm_q[ex_q];
    assign ex_pc_o          = pc_q[ex_q];
    assign ex_pred_target_o = pred_target_q[ex_q];
    assign ex_pred_taken_o  = pred_taken_q[ex_q];

    // CDB reads the head slot, mispredict in bit 0
    assign cdb_valid_o = pop;
    assign cdb_tag_o   = dest_tag_q[head_q];
    assign cdb_value_o = {{(brs_pkg::XLEN-1){1'b0}}, mispredict_q[head_q]};

endmodule

// File: src.f
logic/brs_pkg.sv
logic/rs_entry_buffer.sv
logic/branch_resolver.sv
logic/branch_rs_top.sv
bench/branch_rs_properties.sv
bench/branch_rs_tb.sv
